// File: verilog.f
hw/tnet_ctrl_pkg.sv
hw/tnet_param_regs.sv
hw/tnet_time_cmp.sv
hw/tnet_cmd_fsm.sv
hw/tnet_ctrl_top.sv
verif/tnet_ctrl_checker.sv
verif/tb_tnet_ctrl.sv

// File: verif/tb_tnet_ctrl.sv
module tb_tnet_ctrl
   import tnet_ctrl_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int NUM_TESTS = 27;
localparam int READY_TO  = 1000; // Cycles

logic                 t_clk;
logic                 ps_rst_n;
logic [TIME_W-1:0]    t_time_abs;
logic                 cmd;
tnet_op_e             op;
logic [DATA_W-1:0]    dt1;
logic [DATA_W-1:0]    dt2;
logic                 c_ready;
logic                 time_rst;
logic                 core_start;
logic                 core_stop;
logic                 cmd_err;
logic [ERR_CNT_W-1:0] err_cnt;
logic [DATA_W-1:0]    time_off_dt;
logic [DATA_W-1:0]    tnet_dt1;
logic [DATA_W-1:0]    tnet_dt2;

// Timed entries hold the distance to execution in dt2
tnet_op_e          tab_op  [NUM_TESTS];
logic [DATA_W-1:0] tab_d1  [NUM_TESTS];
logic [DATA_W-1:0] tab_d2  [NUM_TESTS];
string             tab_exp [NUM_TESTS];
int                n_tab;
integer            seed;
bit                aborted;

tnet_ctrl_top i_dut (
   .t_clk_i       ( t_clk       ),
   .ps_rst_ni     ( ps_rst_n    ),
   .t_time_abs_i  ( t_time_abs  ),
   .cmd_i         ( cmd         ),
   .op_i          ( op          ),
   .dt1_i         ( dt1         ),
   .dt2_i         ( dt2         ),
   .c_ready_o     ( c_ready     ),
   .time_rst_o    ( time_rst    ),
   .core_start_o  ( core_start  ),
   .core_stop_o   ( core_stop   ),
   .cmd_err_o     ( cmd_err     ),
   .err_cnt_o     ( err_cnt     ),
   .time_off_dt_o ( time_off_dt ),
   .tnet_dt1_o    ( tnet_dt1    ),
   .tnet_dt2_o    ( tnet_dt2    )
);

tnet_ctrl_checker i_checker (
   .t_clk_i       ( t_clk       ),
   .ps_rst_ni     ( ps_rst_n    ),
   .t_time_abs_i  ( t_time_abs  ),
   .c_ready_i     ( c_ready     ),
   .time_rst_i    ( time_rst    ),
   .core_start_i  ( core_start  ),
   .core_stop_i   ( core_stop   ),
   .cmd_err_i     ( cmd_err     ),
   .err_cnt_i     ( err_cnt     ),
   .time_off_dt_i ( time_off_dt ),
   .tnet_dt1_i    ( tnet_dt1    ),
   .tnet_dt2_i    ( tnet_dt2    )
);

initial begin
   t_clk = 1'b0;
   forever #10 t_clk = ~t_clk;
end

// Node time base
initial begin
   t_time_abs = 48'd1000;
   forever begin
      @(negedge t_clk);
      t_time_abs <= t_time_abs + 1'b1;
   end
end

function automatic bit is_timed(tnet_op_e o);
   return (o == OP_TIME_RST) || (o == OP_CORE_START) || (o == OP_CORE_STOP);
endfunction

task automatic add_entry(input tnet_op_e o, input logic [DATA_W-1:0] d1,
                         input logic [DATA_W-1:0] d2, input string e);
   tab_op[n_tab]  = o;
   tab_d1[n_tab]  = d1;
   tab_d2[n_tab]  = d2;
   tab_exp[n_tab] = e;
   n_tab++;
endtask

//////////////////////////////////////////////////
// Stimulus table
//////////////////////////////////////////////////
task automatic build_table();
   logic [DATA_W-1:0] rtd_val;
   tnet_op_e          c_op;
   n_tab   = 0;
   rtd_val = 32'd64 + ($random(seed) & 32'h3f);
   add_entry(OP_SET_RTD, rtd_val, $random(seed), "accept");
   add_entry(OP_SET_OFF, $random(seed), $random(seed), "accept");
   add_entry(OP_SET_DT, $random(seed), $random(seed), "accept");
   add_entry(OP_CORE_START, 0, rtd_val + 40, "accept");
   add_entry(OP_TIME_RST, 0, rtd_val + 55, "accept");
   add_entry(OP_CORE_STOP, 0, rtd_val + 70, "accept");
   // Long wait so the next two strobes land while busy
   add_entry(OP_CORE_START, 0, rtd_val + 150, "accept");
   add_entry(OP_SET_OFF, $random(seed), $random(seed), "ignore");
   add_entry(OP_SET_DT, $random(seed), $random(seed), "ignore");
   for (int k = 0; k < 17; k++) begin   // Enough to saturate the count
      case (k % 3)
         0:       c_op = OP_TIME_RST;
         1:       c_op = OP_CORE_START;
         default: c_op = OP_CORE_STOP;
      endcase
      add_entry(c_op, 0, 3 + k, "reject");
   end
   add_entry(OP_SET_DT, $random(seed), $random(seed), "accept");
endtask

task automatic wait_ready(output bit timed_out);
   int cnt;
   cnt = 0;
   while (!c_ready && (cnt < READY_TO)) begin
      @(negedge t_clk);
      cnt++;
   end
   timed_out = !c_ready;
   if (timed_out) begin
      $display("Timed out after %0d cycles waiting for c_ready_o", READY_TO);
   end
endtask

initial begin : main
   logic [TIME_W-1:0] now;
   logic [TIME_W-1:0] exec;
   logic [DATA_W-1:0] d1;
   logic [DATA_W-1:0] d2;
   seed     = 32'hcaaf_db8e;
   aborted  = 1'b0;
   ps_rst_n = 1'b0;
   cmd      = 1'b0;
   op       = OP_NOP;
   dt1      = '0;
   dt2      = '0;
   build_table();
   repeat (2) @(negedge t_clk);
   ps_rst_n = 1'b1;
   @(negedge t_clk);
   i_checker.check_reset();
   for (int i = 0; (i < n_tab) && !aborted; i++) begin
      if (tab_exp[i] != "ignore") begin
         wait_ready(aborted);
      end
      if (!aborted) begin
         @(posedge t_clk);
         now = t_time_abs;
         d1  = tab_d1[i];
         d2  = tab_d2[i];
         if (is_timed(tab_op[i])) begin
            exec = now + tab_d2[i];
            d1   = {{(2*DATA_W-TIME_W){1'b0}}, exec[TIME_W-1:DATA_W]};
            d2   = exec[DATA_W-1:0];
         end
         @(negedge t_clk);
         cmd = 1'b1;
         op  = tab_op[i];
         dt1 = d1;
         dt2 = d2;
         @(negedge t_clk);
         cmd = 1'b0;
         op  = OP_NOP;
         i_checker.check_cmd(i + 1, tab_op[i], d1, d2, tab_exp[i]);
      end
   end
   if (!aborted) begin
      wait_ready(aborted);    // Let a pending command finish
   end
   if (i_checker.pend) begin
      $display("Run ended with a timed command still pending");
   end
   $display("Tests passed: %0d, failed: %0d", i_checker.n_pass, i_checker.n_fail);
   if (aborted || i_checker.pend || (i_checker.n_fail != 0)) begin
      $display("Simulation FAILED");
   end else begin
      $display("Simulation PASSED");
   end
   $finish;
end

endmodule

// File: verif/tnet_ctrl_checker.sv
module tnet_ctrl_checker
   import tnet_ctrl_pkg::*;
(
   input  logic                 t_clk_i       ,
   input  logic                 ps_rst_ni     ,
   input  logic [TIME_W-1:0]    t_time_abs_i  ,
   input  logic                 c_ready_i     ,
   input  logic                 time_rst_i    ,
   input  logic                 core_start_i  ,
   input  logic                 core_stop_i   ,
   input  logic                 cmd_err_i     ,
   input  logic [ERR_CNT_W-1:0] err_cnt_i     ,
   input  logic [DATA_W-1:0]    time_off_dt_i ,
   input  logic [DATA_W-1:0]    tnet_dt1_i    ,
   input  logic [DATA_W-1:0]    tnet_dt2_i
);

timeunit 1ns;
timeprecision 1ps;

localparam int PULSE_TO = 500; // Cycles allowed for a pending command

// Reference model of the unit
logic [DATA_W-1:0]    m_rtd = '0;
logic [DATA_W-1:0]    m_off = '0;
logic [DATA_W-1:0]    m_dt1 = '0;
logic [DATA_W-1:0]    m_dt2 = '0;
logic [ERR_CNT_W-1:0] m_err = '0;

logic [TIME_W-1:0]    t_edge;          // Absolute time at the last rising edge
logic                 pend = 1'b0;     // Accepted command waiting for its pulse
tnet_op_e             pend_op;
logic [TIME_W-1:0]    pend_exec;
string                pend_name;
bit                   pend_ok;
int                   wait_cnt = 0;
int                   n_pass = 0;
int                   n_fail = 0;

always @(posedge t_clk_i) begin
   t_edge <= t_time_abs_i;
end

function automatic bit check_val(string what, logic [63:0] got, logic [63:0] exp);
   if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      return 1'b0;
   end
   return 1'b1;
endfunction

function automatic bit params_ok();
   bit ok;
   ok = check_val("time_off_dt_o", time_off_dt_i, m_off);
   ok = check_val("tnet_dt1_o", tnet_dt1_i, m_dt1) && ok;
   ok = check_val("tnet_dt2_o", tnet_dt2_i, m_dt2) && ok;
   return ok;
endfunction

task automatic log_result(input string name, input bit ok);
   if (ok) begin
      n_pass++;
      $display("%s passed", name);
   end else begin
      n_fail++;
      $display("%s failed", name);
   end
endtask

task automatic check_reset();
   bit ok;
   ok = check_val("c_ready_o", c_ready_i, 1);
   ok = check_val("execution pulses", {time_rst_i, core_start_i, core_stop_i}, 0) && ok;
   ok = check_val("cmd_err_o", cmd_err_i, 0) && ok;
   ok = check_val("err_cnt_o", err_cnt_i, 0) && ok;
   ok = params_ok() && ok;
   log_result("Reset state", ok);
endtask

//////////////////////////////////////////////////
// Called on the falling edge after the strobe edge
//////////////////////////////////////////////////
task automatic check_cmd(input int idx, input tnet_op_e op, input logic [DATA_W-1:0] d1,
                         input logic [DATA_W-1:0] d2, input string expect_s);
   string             name;
   logic [TIME_W-1:0] exec;
   bit                ctrl;
   bit                acc;
   bit                ok;
   name = $sformatf("Test %0d %s (%s)", idx, op.name(), expect_s);
   exec = {d1[TIME_W-DATA_W-1:0], d2};
   ctrl = (op == OP_TIME_RST) || (op == OP_CORE_START) || (op == OP_CORE_STOP);
   if (expect_s == "ignore") begin
      ok = check_val("c_ready_o", c_ready_i, 0); // Still busy with the pending command
      ok = params_ok() && ok;
      ok = check_val("err_cnt_o", err_cnt_i, m_err) && ok;
      log_result(name, ok);
   end else if (!ctrl) begin
      case (op)
         OP_SET_RTD: m_rtd = d1;
         OP_SET_OFF: m_off = d1;
         OP_SET_DT: begin
            m_dt1 = d1;
            m_dt2 = d2;
         end
         default: m_rtd = m_rtd;
      endcase
      ok = check_val("c_ready_o", c_ready_i, 1);
      ok = params_ok() && ok;
      log_result(name, ok);
   end else begin
      // Time left counted from the strobe edge
      acc = (exec > t_edge) && ((exec - t_edge) > m_rtd);
      ok  = 1'b1;
      if (acc != (expect_s == "accept")) begin
         $display("[ERROR] %0d ns: %s but the timing rule gives %s", $time, name,
                  acc ? "accept" : "reject");
         ok = 1'b0;
      end
      ok = check_val("c_ready_o", c_ready_i, 0) && ok;
      repeat (CMP_LAT) @(negedge t_clk_i); // Decision cycle
      ok = check_val("cmd_err_o", cmd_err_i, !acc) && ok;
      if (acc) begin
         pend_op   = op;
         pend_exec = exec;
         pend_name = name;
         pend_ok   = ok;
         wait_cnt  = 0;
         pend      = 1'b1;
      end else begin
         if (m_err != '1) begin
            m_err++;    // Saturates
         end
         @(negedge t_clk_i);
         ok = check_val("err_cnt_o", err_cnt_i, m_err) && ok;
         ok = check_val("c_ready_o", c_ready_i, 1) && ok;
         log_result(name, ok);
      end
   end
endtask

//////////////////////////////////////////////////
// Execution pulse monitor
//////////////////////////////////////////////////
always @(negedge t_clk_i) begin : pulse_mon
   logic [2:0] pulses;
   logic [2:0] exp_pulses;
   bit         ok;
   pulses = {time_rst_i, core_start_i, core_stop_i};
   if (ps_rst_ni && (pulses != 3'b000)) begin
      if (!pend) begin
         n_fail++;
         $display("Execution pulse %b at %0d ns with no command pending", pulses, $time);
      end else begin
         exp_pulses = {pend_op == OP_TIME_RST, pend_op == OP_CORE_START,
                       pend_op == OP_CORE_STOP};
         ok = check_val("execution pulses", pulses, exp_pulses) && pend_ok;
         if ((t_edge < pend_exec + 1) || (t_edge > pend_exec + 3)) begin
            $display("[ERROR] %0d ns: pulse at time %0d for execution time %0d",
                     $time, t_edge, pend_exec);
            ok = 1'b0;
         end
         pend = 1'b0;
         log_result(pend_name, ok);
      end
   end else if (pend) begin
      wait_cnt++;
      if (wait_cnt > PULSE_TO) begin
         n_fail++;
         pend = 1'b0;
         $display("%s: the execution pulse never came", pend_name);
      end
   end
end

endmodule

// File: hw/tnet_ctrl_top.sv
module tnet_ctrl_top
   import tnet_ctrl_pkg::*;
(
   input  logic                 t_clk_i       ,
   input  logic                 ps_rst_ni     ,
   input  logic [TIME_W-1:0]    t_time_abs_i  ,
   // Processor control
   input  logic                 cmd_i         ,
   input  tnet_op_e             op_i          ,
   input  logic [DATA_W-1:0]    dt1_i         ,
   input  logic [DATA_W-1:0]    dt2_i         ,
   output logic                 c_ready_o     ,
   // Execution pulses
   output logic                 time_rst_o    ,
   output logic                 core_start_o  ,
   output logic                 core_stop_o   ,
   // Errors
   output logic                 cmd_err_o     ,
   output logic [ERR_CNT_W-1:0] err_cnt_o     ,
   // Parameters
   output logic [DATA_W-1:0]    time_off_dt_o ,
   output logic [DATA_W-1:0]    tnet_dt1_o    ,
   output logic [DATA_W-1:0]    tnet_dt2_o
);

logic              cmd_acc;
logic              load_time;
logic              cmp_vld;
logic              margin_ok;
logic              time_passed;
logic [DATA_W-1:0] rtd;
logic [TIME_W-1:0] exec_time;

// Execution time is dt1 low half on top of dt2
assign exec_time = {dt1_i[TIME_W-DATA_W-1:0], dt2_i};

//////////////////////////////////////////////////
// Instances
//////////////////////////////////////////////////
tnet_cmd_fsm i_cmd_fsm (
   .t_clk_i       ( t_clk_i      ),
   .ps_rst_ni     ( ps_rst_ni    ),
   .cmd_i         ( cmd_i        ),
   .op_i          ( op_i         ),
   .c_ready_o     ( c_ready_o    ),
   .cmd_acc_o     ( cmd_acc      ),
   .load_time_o   ( load_time    ),
   .cmp_vld_i     ( cmp_vld      ),
   .margin_ok_i   ( margin_ok    ),
   .time_passed_i ( time_passed  ),
   .time_rst_o    ( time_rst_o   ),
   .core_start_o  ( core_start_o ),
   .core_stop_o   ( core_stop_o  ),
   .cmd_err_o     ( cmd_err_o    ),
   .err_cnt_o     ( err_cnt_o    )
);

tnet_time_cmp i_time_cmp (
   .t_clk_i       ( t_clk_i      ),
   .ps_rst_ni     ( ps_rst_ni    ),
   .load_time_i   ( load_time    ),
   .exec_time_i   ( exec_time    ),
   .t_time_abs_i  ( t_time_abs_i ),
   .rtd_i         ( rtd          ),
   .cmp_vld_o     ( cmp_vld      ),
   .margin_ok_o   ( margin_ok    ),
   .time_passed_o ( time_passed  )
);

tnet_param_regs i_param_regs (
   .t_clk_i       ( t_clk_i       ),
   .ps_rst_ni     ( ps_rst_ni     ),
   .cmd_acc_i     ( cmd_acc       ),
   .op_i          ( op_i          ),
   .dt1_i         ( dt1_i         ),
   .dt2_i         ( dt2_i         ),
   .rtd_o         ( rtd           ), // Feeds the margin check
   .time_off_dt_o ( time_off_dt_o ),
   .tnet_dt1_o    ( tnet_dt1_o    ),
   .tnet_dt2_o    ( tnet_dt2_o    )
);

endmodule

// File: hw/tnet_cmd_fsm.sv
module tnet_cmd_fsm
   import tnet_ctrl_pkg::*;
(
   input  logic                 t_clk_i       ,
   input  logic                 ps_rst_ni     ,
   // Processor strobe
   input  logic                 cmd_i         ,
   input  tnet_op_e             op_i          ,
   output logic                 c_ready_o     ,
   // To param regs and timer
   output logic                 cmd_acc_o     ,
   output logic                 load_time_o   ,
   // From timer
   input  logic                 cmp_vld_i     ,
   input  logic                 margin_ok_i   ,
   input  logic                 time_passed_i ,
   // Execution pulses
   output logic                 time_rst_o    ,
   output logic                 core_start_o  ,
   output logic                 core_stop_o   ,
   // Error report
   output logic                 cmd_err_o     ,
   output logic [ERR_CNT_W-1:0] err_cnt_o
);

tnet_st_e             state_q, state_d;
tnet_op_e             op_q;            // Pending control opcode
logic                 is_ctrl;
logic                 reject;
logic [ERR_CNT_W-1:0] err_cnt_q;

//////////////////////////////////////////////////
// Strobe accept
//////////////////////////////////////////////////
always_comb begin
   is_ctrl = (op_i == OP_TIME_RST) || (op_i == OP_CORE_START) || (op_i == OP_CORE_STOP);
end

assign c_ready_o   = (state_q == ST_IDLE);
assign cmd_acc_o   = c_ready_o & cmd_i;   // Strobes while busy are dropped
assign load_time_o = cmd_acc_o & is_ctrl;

// Margin too small when the check comes back
assign reject = (state_q == ST_CHECK) & cmp_vld_i & ~margin_ok_i;

//////////////////////////////////////////////////
// State machine
//////////////////////////////////////////////////
always_comb begin
   state_d = state_q;
   case (state_q)
      ST_IDLE: begin
         if (load_time_o) begin
            state_d = ST_LOAD;
         end
      end
      ST_LOAD: begin
         state_d = ST_CHECK;
      end
      ST_CHECK: begin
         if (cmp_vld_i) begin
            state_d = margin_ok_i ? ST_WAIT : ST_IDLE;
         end
      end
      ST_WAIT: begin
         if (time_passed_i) begin
            state_d = ST_FIRE;
         end
      end
      ST_FIRE: begin
         state_d = ST_IDLE;
      end
      default: begin
         state_d = ST_IDLE;
      end
   endcase
end

always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
   if (!ps_rst_ni) begin
      state_q <= ST_IDLE;
   end else begin
      state_q <= state_d;
   end
end

// Captured together with the execution time
always_ff @(posedge t_clk_i) begin
   if (load_time_o) begin
      op_q <= op_i;
   end
end

//////////////////////////////////////////////////
// Outputs
//////////////////////////////////////////////////
assign time_rst_o   = (state_q == ST_FIRE) & (op_q == OP_TIME_RST);
assign core_start_o = (state_q == ST_FIRE) & (op_q == OP_CORE_START);
assign core_stop_o  = (state_q == ST_FIRE) & (op_q == OP_CORE_STOP);
assign cmd_err_o    = reject;

always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
   if (!ps_rst_ni) begin
      err_cnt_q <= '0;
   end else if (reject && (err_cnt_q != {ERR_CNT_W{1'b1}})) begin
      err_cnt_q <= err_cnt_q + 1'b1; // Holds at max
   end
end

assign err_cnt_o = err_cnt_q;

//////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////
a_one_pulse: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
   $onehot0({time_rst_o, core_start_o, core_stop_o}))
   else $error("More than one execution pulse");

// A rejected command must never also execute
a_err_no_exec: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
   cmd_err_o |-> !(time_rst_o || core_start_o || core_stop_o))
   else $error("Error pulse together with execution pulse");

endmodule

// File: hw/tnet_time_cmp.sv
module tnet_time_cmp
   import tnet_ctrl_pkg::*;
(
   input  logic              t_clk_i      ,
   input  logic              ps_rst_ni    ,
   input  logic              load_time_i  ,
   input  logic [TIME_W-1:0] exec_time_i  ,
   input  logic [TIME_W-1:0] t_time_abs_i ,
   input  logic [DATA_W-1:0] rtd_i        ,
   output logic              cmp_vld_o    ,
   output logic              margin_ok_o  ,
   output logic              time_passed_o
);

logic [TIME_W-1:0] exec_time_q;  // Held until next load
logic [TIME_W-1:0] time_left_q;
logic [TIME_W-1:0] margin_q;
logic [TIME_W-1:0] rtd_ext;
logic [CMP_LAT:0]  vld_sr;

assign rtd_ext = {{(TIME_W-DATA_W){1'b0}}, rtd_i};

//////////////////////////////////////////////////
// Subtraction pipe
//////////////////////////////////////////////////
always_ff @(posedge t_clk_i) begin
   if (load_time_i) begin
      exec_time_q <= exec_time_i;
   end
end

// Runs every clock so time_passed tracks the wait
always_ff @(posedge t_clk_i) begin
   time_left_q <= exec_time_q - t_time_abs_i;
   margin_q    <= time_left_q - rtd_ext;
end

// Left time strictly above RTD
assign margin_ok_o   = ~margin_q[TIME_W-1] & (margin_q != '0);
assign time_passed_o = time_left_q[TIME_W-1]; // Sign of left time

//////////////////////////////////////////////////
// Valid shift
//////////////////////////////////////////////////
// Stage 0 is the load edge, margin settles CMP_LAT edges later
always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
   if (!ps_rst_ni) begin
      vld_sr <= '0;
   end else begin
      vld_sr <= {vld_sr[CMP_LAT-1:0], load_time_i};
   end
end

assign cmp_vld_o = vld_sr[CMP_LAT];

//////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////
// Valid is a single cycle, lined up with the registered margin
a_vld_lat: assert property (@(posedge t_clk_i) disable iff (!ps_rst_ni)
   load_time_i |-> ##(CMP_LAT+1) (cmp_vld_o ##1 !cmp_vld_o))
   else $error("Margin valid not %0d clocks after load", CMP_LAT);

endmodule

// File: hw/tnet_param_regs.sv
module tnet_param_regs
   import tnet_ctrl_pkg::*;
(
   input  logic              t_clk_i       ,
   input  logic              ps_rst_ni     ,
   // Accepted strobe and its payload
   input  logic              cmd_acc_i     ,
   input  tnet_op_e          op_i          ,
   input  logic [DATA_W-1:0] dt1_i         ,
   input  logic [DATA_W-1:0] dt2_i         ,
   // Parameter values
   output logic [DATA_W-1:0] rtd_o         ,
   output logic [DATA_W-1:0] time_off_dt_o ,
   output logic [DATA_W-1:0] tnet_dt1_o    ,
   output logic [DATA_W-1:0] tnet_dt2_o
);

logic              we_rtd;
logic              we_off;
logic              we_dt;
logic [DATA_W-1:0] rtd_q;
logic [DATA_W-1:0] off_q;
logic [DATA_W-1:0] dt1_q;
logic [DATA_W-1:0] dt2_q;

//////////////////////////////////////////////////
// Opcode decode
//////////////////////////////////////////////////
always_comb begin
   we_rtd = 1'b0;
   we_off = 1'b0;
   we_dt  = 1'b0;
   if (cmd_acc_i) begin
      case (op_i)
         OP_SET_RTD: begin
            we_rtd = 1'b1;
         end
         OP_SET_OFF: begin
            we_off = 1'b1;
         end
         OP_SET_DT: begin
            we_dt = 1'b1;
         end
         default: begin
            // Control opcodes and NOP leave the registers alone
            we_rtd = 1'b0;
         end
      endcase
   end
end

//////////////////////////////////////////////////
// Registers
//////////////////////////////////////////////////
always_ff @(posedge t_clk_i, negedge ps_rst_ni) begin
   if (!ps_rst_ni) begin
      rtd_q <= '0;
      off_q <= '0;
      dt1_q <= '0;
      dt2_q <= '0;
   end else begin
      if (we_rtd) begin
         rtd_q <= dt1_i;
      end
      if (we_off) begin
         off_q <= dt1_i;
      end
      if (we_dt) begin
         dt1_q <= dt1_i; // Both words together
         dt2_q <= dt2_i;
      end
   end
end

assign rtd_o         = rtd_q;
assign time_off_dt_o = off_q;
assign tnet_dt1_o    = dt1_q;
assign tnet_dt2_o    = dt2_q;

endmodule

// File: hw/tnet_ctrl_pkg.sv
package tnet_ctrl_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int TIME_W    = 48; // Absolute and execution time
   localparam int DATA_W    = 32; // Command data words
   localparam int OP_W      = 4;
   localparam int ERR_CNT_W = 4;  // Saturating error count

   // Load to valid margin in the timer
   localparam int CMP_LAT   = 2;

   //////////////////////////////////////////////////
   // Opcodes
   //////////////////////////////////////////////////
   typedef enum logic [OP_W-1:0] {
      OP_NOP        = 4'd0,
      // Parameter commands, applied at once
      OP_SET_RTD    = 4'd1,
      OP_SET_OFF    = 4'd2,
      OP_SET_DT     = 4'd3,
      // Timed control commands
      OP_TIME_RST   = 4'd4,
      OP_CORE_START = 4'd5,
      OP_CORE_STOP  = 4'd6
   } tnet_op_e;

   //////////////////////////////////////////////////
   // Command FSM states
   //////////////////////////////////////////////////
   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0, // Ready for a strobe
      ST_LOAD  = 3'd1, // Execution time captured
      ST_CHECK = 3'd2, // Waiting on margin
      ST_WAIT  = 3'd3, // Accepted, waiting on time
      ST_FIRE  = 3'd4  // One cycle pulse
   } tnet_st_e;

endpackage
